// File: files.f
+incdir+include
design/mm_pkg.sv
design/qpmm_carry_resolve.sv
design/qpmm_multiplier.sv
design/exp_bit_counter.sv
design/exp_regfile.sv
design/exp_fsm.sv
design/mod_exp_top.sv
dv/tb_mod_exp.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --assert -Wno-fatal -j 0
TOP       = tb_mod_exp
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_mod_exp.sv
`include "mm_defs.svh"

module tb_mod_exp;

    localparam int OP_CYCLES      = 400;
    localparam int MAX_OPS        = 40;
    localparam int TIMEOUT_CYCLES = MAX_OPS * OP_CYCLES;

    logic               clk;
    logic               reset;
    logic               start;
    mm_pkg::mm_op_t     op;
    mm_pkg::mm_word_t   operand_a;
    mm_pkg::mm_word_t   operand_b;
    logic               busy;
    logic               done;
    mm_pkg::mm_word_t   result;

    int     error_count;
    int     check_count;
    int     cycle_count;
    integer seed;

    mod_exp_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .op        (op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .busy      (busy),
        .done      (done),
        .result    (result)
    );

    always #5 clk = ~clk;

    ////////////////////
    // Reference model
    ////////////////////
    function automatic mm_pkg::mm_word_t mod_mul(input mm_pkg::mm_word_t x,
                                                  input mm_pkg::mm_word_t y);
        logic [127:0] full;
        full = 128'(x) * 128'(y);
        return mm_pkg::mm_word_t'(full % 128'(`MM_MODULUS));
    endfunction

    // Square-and-multiply, LSB first
    function automatic mm_pkg::mm_word_t mod_pow(input mm_pkg::mm_word_t x,
                                                  input mm_pkg::mm_word_t e);
        mm_pkg::mm_word_t acc;
        mm_pkg::mm_word_t sq;
        acc = 32'd1;
        sq  = mod_mul(x, 32'd1);
        for (int i = 0; i < `MM_EXP_BITS; i++) begin
            if (e[i])
                acc = mod_mul(acc, sq);
            sq = mod_mul(sq, sq);
        end
        return acc;
    endfunction

    function automatic mm_pkg::mm_word_t random_residue();
        mm_pkg::mm_word_t v;
        v = $random(seed);
        return v % `MM_MODULUS;
    endfunction

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic check_word(input mm_pkg::mm_word_t got, input mm_pkg::mm_word_t expected,
                              input string what);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("error at time %0t: %s: got %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("error at time %0t: %s: got %b, expected %b", $time, what, got, expected);
        end
    endtask

    ////////////////////
    // Drivers
    ////////////////////
    // Called on a falling edge, start held for one cycle
    task automatic issue_start(input mm_pkg::mm_op_t o, input mm_pkg::mm_word_t a,
                               input mm_pkg::mm_word_t b);
        op        = o;
        operand_a = a;
        operand_b = b;
        start     = 1'b1;
        @(negedge clk);
        start     = 1'b0;
    endtask

    task automatic wait_for_done(output mm_pkg::mm_word_t res, output logic finished);
        int waited;
        waited = 0;
        while (done !== 1'b1 && waited < OP_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        finished = (done === 1'b1);
        res      = result;
        if (!finished) begin
            error_count++;
            $display("Operation started before time %0t never signalled done within %0d cycles",
                     $time, OP_CYCLES);
        end
    endtask

    task automatic run_op(input mm_pkg::mm_op_t o, input mm_pkg::mm_word_t a,
                          input mm_pkg::mm_word_t b, input mm_pkg::mm_word_t expected,
                          input string what);
        mm_pkg::mm_word_t res;
        logic             finished;
        issue_start(o, a, b);
        check_flag(busy, 1'b1, {what, ": busy after start"});
        wait_for_done(res, finished);
        if (finished) begin
            check_word(res, expected, what);
            check_flag(busy, 1'b0, {what, ": busy with done"});
        end
    endtask

    ////////////////////
    // Directed tests
    ////////////////////
    task automatic mul_fixed_pairs();
        mm_pkg::mm_word_t x;
        mm_pkg::mm_word_t m1;
        x  = random_residue();
        m1 = `MM_MODULUS - 1;
        run_op(mm_pkg::op_mul, 32'd0, x, 32'd0, "mul 0*x");
        run_op(mm_pkg::op_mul, 32'd1, x, x, "mul 1*x");
        run_op(mm_pkg::op_mul, m1, m1, mod_mul(m1, m1), "mul (M-1)*(M-1)");
    endtask

    task automatic mul_random_pairs();
        mm_pkg::mm_word_t a;
        mm_pkg::mm_word_t b;
        for (int i = 0; i < 10; i++) begin
            a = random_residue();
            b = random_residue();
            run_op(mm_pkg::op_mul, a, b, mod_mul(a, b), $sformatf("mul random pair %0d", i));
        end
    endtask

    task automatic exp_random_pairs();
        mm_pkg::mm_word_t a;
        mm_pkg::mm_word_t e;
        for (int i = 0; i < 6; i++) begin
            a = random_residue();
            e = $random(seed);
            run_op(mm_pkg::op_exp, a, e, mod_pow(a, e), $sformatf("exp random pair %0d", i));
        end
        a = random_residue();
        run_op(mm_pkg::op_exp, a, 32'd0, 32'd1, "exp with exponent 0");
        run_op(mm_pkg::op_exp, 32'd0, 32'h1234_5679, 32'd0, "exp with base 0");
    endtask

    // Both products in flight on every step
    task automatic exp_long_exponents();
        mm_pkg::mm_word_t a;
        a = random_residue();
        run_op(mm_pkg::op_exp, a, 32'hffff_ffff, mod_pow(a, 32'hffff_ffff), "exp all ones");
        run_op(mm_pkg::op_exp, a, 32'h8000_0000, mod_pow(a, 32'h8000_0000), "exp 2^31");
    endtask

    task automatic start_while_busy();
        mm_pkg::mm_word_t a;
        mm_pkg::mm_word_t e;
        mm_pkg::mm_word_t res;
        logic             finished;
        logic             seen;
        a = random_residue();
        e = $random(seed);
        issue_start(mm_pkg::op_exp, a, e);
        repeat (20) @(negedge clk);
        // Second request must be dropped
        issue_start(mm_pkg::op_mul, random_residue(), random_residue());
        wait_for_done(res, finished);
        if (finished)
            check_word(res, mod_pow(a, e), "first result after ignored start");
        seen = 1'b0;
        repeat (100) begin
            @(negedge clk);
            if (done)
                seen = 1'b1;
        end
        check_flag(seen, 1'b0, "second done after ignored start");
        check_flag(busy, 1'b0, "busy after ignored start");
    endtask

    task automatic reset_mid_operation();
        mm_pkg::mm_word_t a;
        mm_pkg::mm_word_t b;
        logic             seen;
        issue_start(mm_pkg::op_exp, random_residue(), 32'hffff_ffff);
        repeat (60) @(negedge clk);
        check_flag(busy, 1'b1, "busy before reset");
        reset = 1'b1;
        repeat (2) @(negedge clk);
        check_flag(busy, 1'b0, "busy during reset");
        reset = 1'b0;
        @(negedge clk);
        check_flag(busy, 1'b0, "busy after reset");
        seen = 1'b0;
        repeat (OP_CYCLES) begin
            @(negedge clk);
            if (done)
                seen = 1'b1;
        end
        check_flag(seen, 1'b0, "done after aborted operation");
        a = random_residue();
        b = random_residue();
        run_op(mm_pkg::op_mul, a, b, mod_mul(a, b), "mul after reset");
        run_op(mm_pkg::op_exp, a, b, mod_pow(a, b), "exp after reset");
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        start       = 1'b0;
        op          = mm_pkg::op_mul;
        operand_a   = '0;
        operand_b   = '0;
        error_count = 0;
        check_count = 0;
        seed        = 32'h190a;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_flag(busy, 1'b0, "busy after reset release");
        check_flag(done, 1'b0, "done after reset release");
        mul_fixed_pairs();
        mul_random_pairs();
        exp_random_pairs();
        exp_long_exponents();
        start_while_busy();
        reset_mid_operation();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized for the longest op_exp times the op count
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: design/mod_exp_top.sv
module mod_exp_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  mm_pkg::mm_op_t   op,
    input  mm_pkg::mm_word_t operand_a,
    input  mm_pkg::mm_word_t operand_b,
    output logic             busy,
    output logic             done,
    output mm_pkg::mm_word_t result
);

    mm_pkg::exp_state_t state;
    mm_pkg::mm_tag_t    mul_tag;
    mm_pkg::mm_tag_t    prod_tag;
    mm_pkg::mm_word_t   mul_a;
    mm_pkg::mm_word_t   mul_b;
    mm_pkg::mm_word_t   prod;
    logic               mul_issue;
    logic               prod_valid;
    logic               issue_second;
    logic               step_advance;
    logic               load;
    logic               bit_now;
    logic               last_step;

    exp_fsm u_fsm (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .op           (op),
        .prod_valid   (prod_valid),
        .prod_tag     (prod_tag),
        .bit_now      (bit_now),
        .last_step    (last_step),
        .state        (state),
        .mul_issue    (mul_issue),
        .mul_tag      (mul_tag),
        .issue_second (issue_second),
        .step_advance (step_advance),
        .load         (load),
        .busy         (busy),
        .done         (done)
    );

    exp_bit_counter u_counter (
        .clk          (clk),
        .reset        (reset),
        .load         (load),
        .exponent     (operand_b),
        .step_advance (step_advance),
        .bit_now      (bit_now),
        .last_step    (last_step)
    );

    exp_regfile u_regfile (
        .clk          (clk),
        .reset        (reset),
        .load         (load),
        .op           (op),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .sel          (state),
        .issue_second (issue_second),
        .prod         (prod),
        .prod_valid   (prod_valid),
        .prod_tag     (prod_tag),
        .mul_a        (mul_a),
        .mul_b        (mul_b),
        .result       (result)
    );

    qpmm_multiplier u_mult (
        .clk        (clk),
        .reset      (reset),
        .issue      (mul_issue),
        .a          (mul_a),
        .b          (mul_b),
        .tag        (mul_tag),
        .prod       (prod),
        .prod_valid (prod_valid),
        .prod_tag   (prod_tag)
    );

endmodule

// File: design/exp_fsm.sv
module exp_fsm (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  mm_pkg::mm_op_t     op,
    input  logic               prod_valid,
    input  mm_pkg::mm_tag_t    prod_tag,
    input  logic               bit_now,
    input  logic               last_step,
    output mm_pkg::exp_state_t state,
    output logic               mul_issue,
    output mm_pkg::mm_tag_t    mul_tag,
    output logic               issue_second,
    output logic               step_advance,
    output logic               load,
    output logic               busy,
    output logic               done
);

    mm_pkg::exp_state_t state_next;
    mm_pkg::mm_op_t     op_q;
    logic               second;
    logic               second_next;
    // Products still in the multiplier
    logic [1:0]         pend;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= mm_pkg::st_idle;
            second <= 1'b0;
            pend   <= '0;
            done   <= 1'b0;
            op_q   <= mm_pkg::op_mul;
        end else begin
            state  <= state_next;
            second <= second_next;
            pend   <= pend + 2'(mul_issue) - 2'(prod_valid);
            done   <= (state == mm_pkg::st_reduce);
            if (load)
                op_q <= op;
        end
    end

    ////////////////////
    // Next state
    ////////////////////
    always_comb begin
        state_next   = state;
        second_next  = 1'b0;
        mul_issue    = 1'b0;
        mul_tag      = mm_pkg::tag_none;
        step_advance = 1'b0;
        load         = 1'b0;
        case (state)
            mm_pkg::st_idle: begin
                if (start) begin
                    load       = 1'b1;
                    state_next = mm_pkg::st_to_mont;
                end
            end
            mm_pkg::st_to_mont: begin
                // base first, acc only for op_mul
                mul_issue = 1'b1;
                mul_tag   = second ? mm_pkg::tag_acc : mm_pkg::tag_base;
                if (op_q == mm_pkg::op_mul && !second)
                    second_next = 1'b1;
                else
                    state_next = mm_pkg::st_wait_conv;
            end
            mm_pkg::st_wait_conv: begin
                if (pend == '0)
                    state_next = (op_q == mm_pkg::op_mul) ? mm_pkg::st_mul : mm_pkg::st_step;
            end
            mm_pkg::st_mul: begin
                mul_issue  = 1'b1;
                mul_tag    = mm_pkg::tag_acc;
                state_next = mm_pkg::st_wait_step;
            end
            mm_pkg::st_step: begin
                mul_issue = 1'b1;
                mul_tag   = second ? mm_pkg::tag_acc : mm_pkg::tag_base;
                if (!second && bit_now)
                    second_next = 1'b1;
                else
                    state_next = mm_pkg::st_wait_step;
            end
            mm_pkg::st_wait_step: begin
                if (pend == '0) begin
                    if (op_q == mm_pkg::op_mul || last_step) begin
                        state_next = mm_pkg::st_from_mont;
                    end else begin
                        step_advance = 1'b1;
                        state_next   = mm_pkg::st_step;
                    end
                end
            end
            mm_pkg::st_from_mont: begin
                mul_issue  = 1'b1;
                mul_tag    = mm_pkg::tag_acc;
                state_next = mm_pkg::st_wait_out;
            end
            mm_pkg::st_wait_out: begin
                if (pend == '0)
                    state_next = mm_pkg::st_reduce;
            end
            mm_pkg::st_reduce: state_next = mm_pkg::st_idle;
            default:           state_next = mm_pkg::st_idle;
        endcase
    end

    assign issue_second = second;
    assign busy         = (state != mm_pkg::st_idle);

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done);
    a_no_idle_issue: assert property (@(posedge clk) disable iff (reset)
        state == mm_pkg::st_idle |-> !mul_issue);
    // Only the back conversion can return while waiting for the output
    a_out_tag: assert property (@(posedge clk) disable iff (reset)
        prod_valid && state == mm_pkg::st_wait_out |-> prod_tag == mm_pkg::tag_acc);

endmodule

// File: design/exp_regfile.sv
`include "mm_defs.svh"

module exp_regfile (
    input  logic                clk,
    input  logic                reset,
    input  logic                load,
    input  mm_pkg::mm_op_t      op,
    input  mm_pkg::mm_word_t    operand_a,
    input  mm_pkg::mm_word_t    operand_b,
    input  mm_pkg::exp_state_t  sel,
    input  logic                issue_second,
    input  mm_pkg::mm_word_t    prod,
    input  logic                prod_valid,
    input  mm_pkg::mm_tag_t     prod_tag,
    output mm_pkg::mm_word_t    mul_a,
    output mm_pkg::mm_word_t    mul_b,
    output mm_pkg::mm_word_t    result
);

    mm_pkg::mm_word_t acc;
    mm_pkg::mm_word_t base;

    ////////////////////
    // Registers
    ////////////////////
    always_ff @(posedge clk) begin
        if (load) begin
            if (op == mm_pkg::op_exp) begin
                // Montgomery one, no conversion needed
                acc  <= `MM_R_MOD;
                base <= operand_a;
            end else begin
                acc  <= operand_a;
                base <= operand_b;
            end
        end else if (prod_valid) begin
            case (prod_tag)
                mm_pkg::tag_acc:  acc  <= prod;
                mm_pkg::tag_base: base <= prod;
                default: ;
            endcase
        end
    end

    // Final reduction, acc is below 2M here
    always_ff @(posedge clk) begin
        if (sel == mm_pkg::st_reduce)
            result <= (acc >= `MM_MODULUS) ? acc - `MM_MODULUS : acc;
    end

    ////////////////////
    // Operand select
    ////////////////////
    always_comb begin
        case (sel)
            mm_pkg::st_to_mont: begin
                mul_a = issue_second ? acc : base;
                mul_b = `MM_R2_MOD;
            end
            mm_pkg::st_step: begin
                // Square first, then acc*base with the old base
                mul_a = issue_second ? acc : base;
                mul_b = base;
            end
            mm_pkg::st_from_mont: begin
                mul_a = acc;
                mul_b = `MM_WIDTH'(1);
            end
            default: begin
                mul_a = acc;
                mul_b = base;
            end
        endcase
    end

    a_result_reduced: assert property (@(posedge clk) disable iff (reset)
        sel == mm_pkg::st_reduce |=> result < `MM_MODULUS);

endmodule

// File: design/exp_bit_counter.sv
`include "mm_defs.svh"

module exp_bit_counter (
    input  logic             clk,
    input  logic             reset,
    input  logic             load,
    input  mm_pkg::mm_word_t exponent,
    input  logic             step_advance,
    output logic             bit_now,
    output logic             last_step
);

    mm_pkg::mm_word_t                shreg;
    logic [$clog2(`MM_EXP_BITS)-1:0] steps_left;

    always_ff @(posedge clk) begin
        if (reset) begin
            shreg      <= '0;
            steps_left <= '0;
        end else if (load) begin
            shreg      <= exponent;
            steps_left <= $clog2(`MM_EXP_BITS)'(`MM_EXP_BITS - 1);
        end else if (step_advance) begin
            // LSB first
            shreg      <= shreg >> 1;
            steps_left <= steps_left - 1'b1;
        end
    end

    assign bit_now   = shreg[0];
    assign last_step = (steps_left == '0);

endmodule

// File: design/qpmm_multiplier.sv
`include "mm_defs.svh"

module qpmm_multiplier (
    input  logic             clk,
    input  logic             reset,
    input  logic             issue,
    input  mm_pkg::mm_word_t a,
    input  mm_pkg::mm_word_t b,
    input  mm_pkg::mm_tag_t  tag,
    output mm_pkg::mm_word_t prod,
    output logic             prod_valid,
    output mm_pkg::mm_tag_t  prod_tag
);

    // Operand delay lines, stage k feeds row k
    mm_pkg::mm_word_t a_pipe [1:`MM_DIGITS-1];
    mm_pkg::mm_word_t b_pipe [1:`MM_DIGITS-1];

    // Registered redundant sums after each row
    mm_pkg::mm_col_t s [1:`MM_ROWS][`MM_COLS];

    logic [`MM_LATENCY-1:0] vld_pipe;
    mm_pkg::mm_tag_t        tag_pipe [`MM_LATENCY];

    always_ff @(posedge clk) begin
        a_pipe[1] <= a;
        b_pipe[1] <= b;
        for (int k = 2; k < `MM_DIGITS; k++) begin
            a_pipe[k] <= a_pipe[k-1];
            b_pipe[k] <= b_pipe[k-1];
        end
    end

    ////////////////////
    // Systolic rows
    ////////////////////
    for (genvar i = 0; i < `MM_ROWS; i++) begin : g_row
        mm_pkg::mm_col_t   cur [`MM_COLS];
        mm_pkg::mm_col_t   ab  [`MM_COLS];
        mm_pkg::mm_col_t   nxt [`MM_COLS];
        mm_pkg::mm_digit_t q;

        if (i == 0) begin : g_first
            always_comb begin
                for (int j = 0; j < `MM_COLS; j++) begin
                    cur[j] = '0;
                    ab[j] = '0;
                    if (j < `MM_DIGITS)
                        ab[j] = `MM_COL_WIDTH'(a[`MM_DIGIT*j +: `MM_DIGIT] * b[`MM_DIGIT-1:0]);
                end
            end
        end else if (i < `MM_DIGITS) begin : g_mid
            always_comb begin
                for (int j = 0; j < `MM_COLS; j++) begin
                    cur[j] = s[i][j];
                    ab[j] = '0;
                    if (j < `MM_DIGITS)
                        ab[j] = `MM_COL_WIDTH'(a_pipe[i][`MM_DIGIT*j +: `MM_DIGIT]
                                * b_pipe[i][`MM_DIGIT*i +: `MM_DIGIT]);
                end
            end
        end else begin : g_tail
            // Upper digits of b are zero, quotient term only
            always_comb begin
                for (int j = 0; j < `MM_COLS; j++) begin
                    cur[j] = s[i][j];
                    ab[j] = '0;
                end
            end
        end

        // Quotient digit of this row, already exact in column 0
        assign q = cur[0][`MM_DIGIT-1:0];

        always_comb begin
            for (int j = 0; j < `MM_COLS; j++) begin
                if (j == 0)
                    nxt[j] = cur[1] + (cur[0] >> `MM_DIGIT);
                else if (j + 1 < `MM_COLS)
                    nxt[j] = cur[j+1];
                else
                    nxt[j] = '0;
                if (j >= 1 && j - 1 < `MM_DIGITS)
                    nxt[j] = nxt[j] + `MM_COL_WIDTH'(q
                             * `MM_DIGIT'(`MM_MPP >> (`MM_DIGIT * (j - 1))));
                nxt[j] = nxt[j] + ab[j];
            end
        end

        always_ff @(posedge clk) begin
            s[i+1] <= nxt;
        end
    end

    qpmm_carry_resolve u_resolve (
        .clk     (clk),
        .columns (s[`MM_ROWS]),
        .result  (prod)
    );

    // Valid and tag follow the products through the array
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[`MM_LATENCY-2:0], issue};
        end
    end

    always_ff @(posedge clk) begin
        tag_pipe[0] <= tag;
        for (int k = 1; k < `MM_LATENCY; k++)
            tag_pipe[k] <= tag_pipe[k-1];
    end

    assign prod_valid = vld_pipe[`MM_LATENCY-1];
    assign prod_tag   = tag_pipe[`MM_LATENCY-1];

    a_valid_tag: assert property (@(posedge clk) disable iff (reset)
        prod_valid |-> prod_tag != mm_pkg::tag_none);

endmodule

// File: design/qpmm_carry_resolve.sv
`include "mm_defs.svh"

module qpmm_carry_resolve (
    input  logic             clk,
    input  mm_pkg::mm_col_t  columns [`MM_COLS],
    output mm_pkg::mm_word_t result
);

    localparam int HALF = (`MM_COLS + 1) / 2;

    logic [2*`MM_WIDTH-1:0] lo_comb;
    logic [2*`MM_WIDTH-1:0] hi_comb;
    logic [2*`MM_WIDTH-1:0] lo_sum;
    logic [2*`MM_WIDTH-1:0] hi_sum;

    // Weighted sums of the lower and upper column groups
    always_comb begin
        lo_comb = '0;
        hi_comb = '0;
        for (int j = 0; j < `MM_COLS; j++) begin
            if (j < HALF)
                lo_comb = lo_comb + ((2*`MM_WIDTH)'(columns[j]) << (`MM_DIGIT * j));
            else
                hi_comb = hi_comb
                          + ((2*`MM_WIDTH)'(columns[j]) << (`MM_DIGIT * (j - HALF)));
        end
    end

    always_ff @(posedge clk) begin
        lo_sum <= lo_comb;
        hi_sum <= hi_comb;
    end

    // Second stage, the final shifted add
    always_ff @(posedge clk) begin
        result <= `MM_WIDTH'(lo_sum + (hi_sum << (`MM_DIGIT * HALF)));
    end

endmodule

// File: design/mm_pkg.sv
`include "mm_defs.svh"

package mm_pkg;

    typedef logic [`MM_WIDTH-1:0]     mm_word_t;
    typedef logic [`MM_DIGIT-1:0]     mm_digit_t;
    typedef logic [`MM_COL_WIDTH-1:0] mm_col_t;

    typedef enum logic {
        op_mul,
        op_exp
    } mm_op_t;

    // Controller states
    typedef enum logic [3:0] {
        st_idle,
        st_to_mont,
        st_wait_conv,
        st_mul,
        st_step,
        st_wait_step,
        st_from_mont,
        st_wait_out,
        st_reduce
    } exp_state_t;

    // Register a product is written back to
    typedef enum logic [1:0] {
        tag_acc,
        tag_base,
        tag_none
    } mm_tag_t;

endpackage

// File: include/mm_defs.svh
`ifndef MM_DEFS_SVH
`define MM_DEFS_SVH

// Datapath geometry
`define MM_WIDTH      32
`define MM_DIGIT      8
`define MM_DIGITS     4
`define MM_QDELAY     1
`define MM_ROWS       6
`define MM_COLS       5
`define MM_COL_WIDTH  24

// 6 array rows plus 2 carry resolve stages
`define MM_LATENCY    8

// Modulus 2^31-1 and its derived constants
`define MM_MODULUS    32'h7fff_ffff
// (M+1)/2^16, M' is 1 since M is -1 mod 2^16
`define MM_MPP        32'h0000_8000
// 2^40 mod M
`define MM_R_MOD      32'h0000_0200
// 2^80 mod M
`define MM_R2_MOD     32'h0004_0000

`define MM_EXP_BITS   32

`endif
